// ==== logic/chip_io_pkg.sv ====
// Chip I/O package
// Widths, RAM geometry, monitored software addresses and JTAG constants
`default_nettype none

package chip_io_pkg;

  // Data path and RAM
  localparam int DATA_W    = 32;
  localparam int RAM_AW    = 10;
  localparam int RAM_WORDS = 1 << RAM_AW;

  // SPI frame is command bit, address field, data word
  localparam int FRAME_ADDR_W   = 15;
  localparam int SPI_FRAME_BITS = 1 + FRAME_ADDR_W + DATA_W;
  localparam int SPI_CNT_W      = 6;

  // Word addresses watched by the software status monitor
  localparam logic [RAM_AW-1:0] SW_TEST_STATUS_ADDR = 10'h3F8;
  localparam logic [RAM_AW-1:0] SW_LOG_ADDR         = 10'h3FC;

  // JTAG instruction register and IDCODE
  localparam int                   JTAG_IR_W       = 4;
  localparam logic [JTAG_IR_W-1:0] JTAG_IR_IDCODE  = 4'b0001;
  localparam logic [JTAG_IR_W-1:0] JTAG_IR_BYPASS  = 4'b1111;
  localparam logic [JTAG_IR_W-1:0] JTAG_IR_CAPTURE = 4'b0101;
  localparam logic [DATA_W-1:0]    JTAG_IDCODE     = 32'h1A2B_3C4D;

  // TAP controller states
  localparam int                  TAP_ST_W       = 4;
  localparam logic [TAP_ST_W-1:0] TAP_TLR        = 4'h0;
  localparam logic [TAP_ST_W-1:0] TAP_RTI        = 4'h1;
  localparam logic [TAP_ST_W-1:0] TAP_SELECT_DR  = 4'h2;
  localparam logic [TAP_ST_W-1:0] TAP_CAPTURE_DR = 4'h3;
  localparam logic [TAP_ST_W-1:0] TAP_SHIFT_DR   = 4'h4;
  localparam logic [TAP_ST_W-1:0] TAP_EXIT1_DR   = 4'h5;
  localparam logic [TAP_ST_W-1:0] TAP_PAUSE_DR   = 4'h6;
  localparam logic [TAP_ST_W-1:0] TAP_EXIT2_DR   = 4'h7;
  localparam logic [TAP_ST_W-1:0] TAP_UPDATE_DR  = 4'h8;
  localparam logic [TAP_ST_W-1:0] TAP_SELECT_IR  = 4'h9;
  localparam logic [TAP_ST_W-1:0] TAP_CAPTURE_IR = 4'hA;
  localparam logic [TAP_ST_W-1:0] TAP_SHIFT_IR   = 4'hB;
  localparam logic [TAP_ST_W-1:0] TAP_EXIT1_IR   = 4'hC;
  localparam logic [TAP_ST_W-1:0] TAP_PAUSE_IR   = 4'hD;
  localparam logic [TAP_ST_W-1:0] TAP_EXIT2_IR   = 4'hE;
  localparam logic [TAP_ST_W-1:0] TAP_UPDATE_IR  = 4'hF;

endpackage

`default_nettype wire

// ==== logic/strap_sampler.sv ====
// Strap sampler
// Latches the jtag_spi_n and bootstrap straps once after reset release
`timescale 1ns/1ps
`default_nettype none

module strap_sampler (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic jtag_spi_n_pad_i,
  input  logic bootstrap_pad_i,
  output logic mode_jtag_o,
  output logic bootstrap_o,
  output logic straps_valid_o
);

  logic mode_jtag_q;
  logic bootstrap_q;
  logic valid_q;

  // One-shot capture, re-armed only by reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mode_jtag_q <= 1'b0;
      bootstrap_q <= 1'b0;
      valid_q     <= 1'b0;
    end else if (!valid_q) begin
      mode_jtag_q <= jtag_spi_n_pad_i;
      bootstrap_q <= bootstrap_pad_i;
      valid_q     <= 1'b1;
    end
  end

  assign mode_jtag_o    = mode_jtag_q;
  assign bootstrap_o    = bootstrap_q;
  assign straps_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== logic/dps_pin_mux.sv ====
// DPS pin mux
// Synchronizes the shared debug pads, detects clock edges and steers the
// pads to the JTAG TAP or the SPI device according to the latched strap
`timescale 1ns/1ps
`default_nettype none

module dps_pin_mux (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic mode_jtag_i,
  input  logic straps_valid_i,
  input  logic dps0_i,
  input  logic dps1_i,
  input  logic dps3_i,
  input  logic dps4_i,
  input  logic tdo_i,
  input  logic miso_i,
  output logic tck_rise_o,
  output logic tck_fall_o,
  output logic tms_o,
  output logic tdi_o,
  output logic trst_n_o,
  output logic sck_rise_o,
  output logic sck_fall_o,
  output logic mosi_o,
  output logic csb_o,
  output logic dps2_o
);

  // Bit order is dps4, dps3, dps1, dps0
  logic [3:0] pad_in;
  logic [3:0] sync1_q, sync2_q, sync3_q;
  logic       rise_q, fall_q;
  logic       jtag_sel, spi_sel;

  assign pad_in = {dps4_i, dps3_i, dps1_i, dps0_i};

  // Two sync flops, then a third stage for edge detection
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= 4'b0100;  // tms and csb idle high
      sync2_q <= 4'b0100;
      sync3_q <= 4'b0100;
      rise_q  <= 1'b0;
      fall_q  <= 1'b0;
    end else begin
      sync1_q <= pad_in;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
      rise_q  <= sync2_q[0] & ~sync3_q[0];
      fall_q  <= ~sync2_q[0] & sync3_q[0];
    end
  end

  assign jtag_sel = straps_valid_i & mode_jtag_i;
  assign spi_sel  = straps_valid_i & ~mode_jtag_i;

  // Unselected side sees idle levels
  assign tck_rise_o = jtag_sel & rise_q;
  assign tck_fall_o = jtag_sel & fall_q;
  assign tms_o      = jtag_sel ? sync3_q[2] : 1'b1;
  assign tdi_o      = sync3_q[1];
  assign trst_n_o   = jtag_sel & sync3_q[3];

  assign sck_rise_o = spi_sel & rise_q;
  assign sck_fall_o = spi_sel & fall_q;
  assign mosi_o     = sync3_q[1];
  assign csb_o      = spi_sel ? sync3_q[2] : 1'b1;

  assign dps2_o = jtag_sel ? tdo_i : (spi_sel & miso_i);

endmodule

`default_nettype wire

// ==== logic/jtag_tap.sv ====
// JTAG TAP controller
// 16-state TAP with a 4-bit IR, supporting IDCODE and BYPASS only
`timescale 1ns/1ps
`default_nettype none

module jtag_tap (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic tck_rise_i,
  input  logic tck_fall_i,
  input  logic tms_i,
  input  logic tdi_i,
  input  logic trst_n_i,
  output logic tdo_o
);
  import chip_io_pkg::*;

  logic [TAP_ST_W-1:0]  state_q, state_d;
  logic [JTAG_IR_W-1:0] ir_q, ir_shift_q;
  logic [DATA_W-1:0]    idcode_q;
  logic                 bypass_q;
  logic                 sel_idcode;
  logic                 tdo_q;

  // Anything other than IDCODE falls back to BYPASS
  assign sel_idcode = (ir_q == JTAG_IR_IDCODE);

  always_comb begin
    case (state_q)
      TAP_TLR:        state_d = tms_i ? TAP_TLR       : TAP_RTI;
      TAP_RTI:        state_d = tms_i ? TAP_SELECT_DR : TAP_RTI;
      TAP_SELECT_DR:  state_d = tms_i ? TAP_SELECT_IR : TAP_CAPTURE_DR;
      TAP_CAPTURE_DR: state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
      TAP_SHIFT_DR:   state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
      TAP_EXIT1_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
      TAP_PAUSE_DR:   state_d = tms_i ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
      TAP_EXIT2_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
      TAP_UPDATE_DR:  state_d = tms_i ? TAP_SELECT_DR : TAP_RTI;
      TAP_SELECT_IR:  state_d = tms_i ? TAP_TLR       : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR: state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
      TAP_SHIFT_IR:   state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
      TAP_EXIT1_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
      TAP_PAUSE_IR:   state_d = tms_i ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
      TAP_EXIT2_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
      TAP_UPDATE_IR:  state_d = tms_i ? TAP_SELECT_DR : TAP_RTI;
      default:        state_d = TAP_TLR;
    endcase
  end

  // State and IR; trst_n acts as a synchronous TAP reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= TAP_TLR;
      ir_q    <= JTAG_IR_IDCODE;
    end else if (!trst_n_i) begin
      state_q <= TAP_TLR;
      ir_q    <= JTAG_IR_IDCODE;
    end else if (tck_rise_i) begin
      state_q <= state_d;
      if (state_d == TAP_TLR) begin
        ir_q <= JTAG_IR_IDCODE;
      end else if (state_q == TAP_UPDATE_IR) begin
        ir_q <= ir_shift_q;
      end
    end
  end

  // Capture and shift paths
  always_ff @(posedge clk_i) begin
    if (tck_rise_i) begin
      case (state_q)
        TAP_CAPTURE_IR: ir_shift_q <= JTAG_IR_CAPTURE;
        TAP_SHIFT_IR:   ir_shift_q <= {tdi_i, ir_shift_q[JTAG_IR_W-1:1]};
        TAP_CAPTURE_DR: begin
          idcode_q <= JTAG_IDCODE;
          bypass_q <= 1'b0;
        end
        TAP_SHIFT_DR: begin
          idcode_q <= {tdi_i, idcode_q[DATA_W-1:1]};
          bypass_q <= tdi_i;
        end
        default: ;
      endcase
    end
  end

  // tdo moves on the falling edge, LSB first
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tdo_q <= 1'b0;
    end else if (tck_fall_i) begin
      if (state_q == TAP_SHIFT_IR) begin
        tdo_q <= ir_shift_q[0];
      end else if (state_q == TAP_SHIFT_DR) begin
        tdo_q <= sel_idcode ? idcode_q[0] : bypass_q;
      end else begin
        tdo_q <= 1'b0;
      end
    end
  end

  assign tdo_o = tdo_q;

endmodule

`default_nettype wire

// ==== logic/spi_frame_rx.sv ====
// SPI frame receiver, mode 0
// Decodes 48-bit command frames into RAM writes and reads and shifts read data out
`timescale 1ns/1ps
`default_nettype none

module spi_frame_rx (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             sck_rise_i,
  input  logic                             sck_fall_i,
  input  logic                             mosi_i,
  input  logic                             csb_i,
  input  logic [chip_io_pkg::DATA_W-1:0]   ram_rdata_i,
  output logic                             miso_o,
  output logic                             ram_req_o,
  output logic                             ram_we_o,
  output logic [chip_io_pkg::RAM_AW-1:0]   ram_addr_o,
  output logic [chip_io_pkg::DATA_W-1:0]   ram_wdata_o
);
  import chip_io_pkg::*;

  logic [SPI_CNT_W-1:0]      bit_cnt_q;
  logic [SPI_FRAME_BITS-1:0] shift_q;
  logic [DATA_W-1:0]         tx_q;
  logic                      wr_req_q, rd_req_q, rd_load_q;
  logic                      tx_active_q, miso_q;
  logic                      addr_done, last_bit;

  // Command and address complete after 16 bits, whole frame after 48
  assign addr_done = sck_rise_i & ~csb_i & (bit_cnt_q == SPI_CNT_W'(FRAME_ADDR_W));
  assign last_bit  = sck_rise_i & ~csb_i & (bit_cnt_q == SPI_CNT_W'(SPI_FRAME_BITS - 1));

  always_ff @(posedge clk_i) begin
    if (sck_rise_i && !csb_i) begin
      shift_q <= {shift_q[SPI_FRAME_BITS-2:0], mosi_i};
    end
  end

  // Counter saturates at 48, so extra bits never cause a second write
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_q <= '0;
      wr_req_q  <= 1'b0;
      rd_req_q  <= 1'b0;
      rd_load_q <= 1'b0;
    end else begin
      wr_req_q  <= last_bit & shift_q[SPI_FRAME_BITS-2];
      rd_req_q  <= addr_done & ~shift_q[FRAME_ADDR_W-1];
      rd_load_q <= rd_req_q;
      if (csb_i) begin
        bit_cnt_q <= '0;
      end else if (sck_rise_i && bit_cnt_q != SPI_CNT_W'(SPI_FRAME_BITS)) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // Read data shifter, MSB first
  always_ff @(posedge clk_i) begin
    if (rd_load_q) begin
      tx_q <= ram_rdata_i;
    end else if (sck_fall_i && tx_active_q) begin
      tx_q <= {tx_q[DATA_W-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_active_q <= 1'b0;
      miso_q      <= 1'b0;
    end else if (csb_i) begin
      tx_active_q <= 1'b0;
      miso_q      <= 1'b0;
    end else begin
      if (rd_load_q) begin
        tx_active_q <= 1'b1;
      end
      if (sck_fall_i) begin
        miso_q <= tx_active_q & tx_q[DATA_W-1];
      end
    end
  end

  // Upper address bits beyond the RAM size are dropped
  assign ram_req_o   = wr_req_q | rd_req_q;
  assign ram_we_o    = wr_req_q;
  assign ram_addr_o  = rd_req_q ? shift_q[RAM_AW-1:0] : shift_q[DATA_W +: RAM_AW];
  assign ram_wdata_o = shift_q[DATA_W-1:0];
  assign miso_o      = miso_q;

endmodule

`default_nettype wire

// ==== logic/main_ram.sv ====
// Main RAM
// Single-port word RAM with a registered read port
`timescale 1ns/1ps
`default_nettype none

module main_ram (
  input  logic                           clk_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [chip_io_pkg::RAM_AW-1:0] addr_i,
  input  logic [chip_io_pkg::DATA_W-1:0] wdata_i,
  output logic [chip_io_pkg::DATA_W-1:0] rdata_o
);
  import chip_io_pkg::*;

  logic [DATA_W-1:0] mem_q [RAM_WORDS];
  logic [DATA_W-1:0] rdata_q;

  // Read data holds until the next read request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== logic/sw_status_monitor.sv ====
// Software status monitor
// Snoops RAM writes to the test status and log words and reports them
`timescale 1ns/1ps
`default_nettype none

module sw_status_monitor (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           wr_strobe_i,
  input  logic [chip_io_pkg::RAM_AW-1:0] wr_addr_i,
  input  logic [chip_io_pkg::DATA_W-1:0] wr_data_i,
  output logic                           test_status_valid_o,
  output logic                           log_valid_o,
  output logic [chip_io_pkg::DATA_W-1:0] test_status_o,
  output logic [chip_io_pkg::DATA_W-1:0] log_data_o
);
  import chip_io_pkg::*;

  logic              status_hit, log_hit;
  logic              status_valid_q, log_valid_q;
  logic [DATA_W-1:0] status_q, log_q;

  assign status_hit = wr_strobe_i & (wr_addr_i == SW_TEST_STATUS_ADDR);
  assign log_hit    = wr_strobe_i & (wr_addr_i == SW_LOG_ADDR);

  // One-cycle pulse, data sticks until the next hit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_valid_q <= 1'b0;
      log_valid_q    <= 1'b0;
      status_q       <= '0;
      log_q          <= '0;
    end else begin
      status_valid_q <= status_hit;
      log_valid_q    <= log_hit;
      if (status_hit) begin
        status_q <= wr_data_i;
      end
      if (log_hit) begin
        log_q <= wr_data_i;
      end
    end
  end

  assign test_status_valid_o = status_valid_q;
  assign log_valid_o         = log_valid_q;
  assign test_status_o       = status_q;
  assign log_data_o          = log_q;

endmodule

`default_nettype wire

// ==== logic/chip_io_top.sv ====
// Chip I/O top level
// Strap sampling, DPS pad mux, JTAG TAP, SPI device, main RAM and status monitor
`timescale 1ns/1ps
`default_nettype none

module chip_io_top (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           dps0_i,
  input  logic                           dps1_i,
  input  logic                           dps3_i,
  input  logic                           dps4_i,
  input  logic                           dps6_i,
  input  logic                           dps7_i,
  output logic                           dps2_o,
  output logic                           bootstrap_o,
  output logic                           test_status_valid_o,
  output logic                           log_valid_o,
  output logic [chip_io_pkg::DATA_W-1:0] test_status_o,
  output logic [chip_io_pkg::DATA_W-1:0] log_data_o
);
  import chip_io_pkg::*;

  logic              mode_jtag, straps_valid;
  logic              tck_rise, tck_fall, tms, tdi, trst_n, tdo;
  logic              sck_rise, sck_fall, mosi, csb, miso;
  logic              ram_req, ram_we, wr_strobe;
  logic [RAM_AW-1:0] ram_addr;
  logic [DATA_W-1:0] ram_wdata, ram_rdata;

  strap_sampler strap_sampler_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .jtag_spi_n_pad_i (dps6_i),
    .bootstrap_pad_i  (dps7_i),
    .mode_jtag_o      (mode_jtag),
    .bootstrap_o      (bootstrap_o),
    .straps_valid_o   (straps_valid)
  );

  dps_pin_mux dps_pin_mux_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .mode_jtag_i    (mode_jtag),
    .straps_valid_i (straps_valid),
    .dps0_i         (dps0_i),
    .dps1_i         (dps1_i),
    .dps3_i         (dps3_i),
    .dps4_i         (dps4_i),
    .tdo_i          (tdo),
    .miso_i         (miso),
    .tck_rise_o     (tck_rise),
    .tck_fall_o     (tck_fall),
    .tms_o          (tms),
    .tdi_o          (tdi),
    .trst_n_o       (trst_n),
    .sck_rise_o     (sck_rise),
    .sck_fall_o     (sck_fall),
    .mosi_o         (mosi),
    .csb_o          (csb),
    .dps2_o         (dps2_o)
  );

  jtag_tap jtag_tap_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .tck_rise_i (tck_rise),
    .tck_fall_i (tck_fall),
    .tms_i      (tms),
    .tdi_i      (tdi),
    .trst_n_i   (trst_n),
    .tdo_o      (tdo)
  );

  spi_frame_rx spi_frame_rx_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .sck_rise_i  (sck_rise),
    .sck_fall_i  (sck_fall),
    .mosi_i      (mosi),
    .csb_i       (csb),
    .ram_rdata_i (ram_rdata),
    .miso_o      (miso),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata)
  );

  main_ram main_ram_inst (
    .clk_i   (clk_i),
    .req_i   (ram_req),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  // Monitor snoops the same write the RAM takes
  assign wr_strobe = ram_req & ram_we;

  sw_status_monitor sw_status_monitor_inst (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .wr_strobe_i         (wr_strobe),
    .wr_addr_i           (ram_addr),
    .wr_data_i           (ram_wdata),
    .test_status_valid_o (test_status_valid_o),
    .log_valid_o         (log_valid_o),
    .test_status_o       (test_status_o),
    .log_data_o          (log_data_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_chip_io.sv ====
// Chip I/O testbench
// Drives the DPS pads as SPI host and JTAG probe, and checks straps, RAM
// traffic, the status monitor and the TAP against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_chip_io;
  import chip_io_pkg::*;

  localparam int CLK_NS     = 20;
  localparam int HALF_CLKS  = 8;
  localparam int NUM_WRITES = 20;
  // SPI frames plus an allowance for resets and JTAG scans
  localparam int     NUM_FRAMES  = 2 * NUM_WRITES + 24;
  localparam longint FRAME_NS    = longint'(SPI_FRAME_BITS + 2) * 2 * HALF_CLKS * CLK_NS;
  localparam longint WATCHDOG_NS = NUM_FRAMES * FRAME_NS + 100_000;

  logic              clk, arst_n;
  logic              dps0, dps1, dps3, dps4, dps6, dps7;
  logic              dps2, bootstrap, status_valid, log_valid;
  logic [DATA_W-1:0] status_data, log_data;

  int mismatch_cnt  = 0;
  int other_cnt     = 0;
  int status_pulses = 0;
  int log_pulses    = 0;

  logic [31:0]             lcg_state = 32'd20540;
  logic [DATA_W-1:0]       model [int];
  logic [FRAME_ADDR_W-1:0] addr_list [$];

  chip_io_top chip_io_top_inst (
    .clk_i               (clk),
    .arst_n_i            (arst_n),
    .dps0_i              (dps0),
    .dps1_i              (dps1),
    .dps3_i              (dps3),
    .dps4_i              (dps4),
    .dps6_i              (dps6),
    .dps7_i              (dps7),
    .dps2_o              (dps2),
    .bootstrap_o         (bootstrap),
    .test_status_valid_o (status_valid),
    .log_valid_o         (log_valid),
    .test_status_o       (status_data),
    .log_data_o          (log_data)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  // Count monitor pulses away from the active edge
  always @(negedge clk) begin
    if (status_valid) begin
      status_pulses++;
    end
    if (log_valid) begin
      log_pulses++;
    end
  end

  // Monitor pulses are one clk wide and never coincide
  assert property (@(posedge clk) disable iff (!arst_n) status_valid |=> !status_valid)
    else begin
      other_cnt++;
      $display("Error at %0t: test_status_valid_o stayed high for two cycles", $time);
    end

  assert property (@(posedge clk) disable iff (!arst_n) !(status_valid && log_valid))
    else begin
      other_cnt++;
      $display("Error at %0t: status and log pulses fired together", $time);
    end

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    assert (act === exp)
      else begin
        mismatch_cnt++;
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Reset with the given straps and check capture and hold
  task automatic apply_reset(input logic jtag_mode, input logic boot);
    @(negedge clk);
    arst_n = 1'b0;
    dps6   = jtag_mode;
    dps7   = boot;
    dps0   = 1'b0;
    dps1   = 1'b0;
    dps3   = 1'b1;
    dps4   = 1'b1;
    wait_clks(8);
    check_value("dps2_o", 32'(1'b0), 32'(dps2));
    check_value("bootstrap_o", 32'(1'b0), 32'(bootstrap));
    check_value("test_status_valid_o", 32'(1'b0), 32'(status_valid));
    check_value("log_valid_o", 32'(1'b0), 32'(log_valid));
    check_value("test_status_o", '0, status_data);
    check_value("log_data_o", '0, log_data);
    arst_n = 1'b1;
    wait_clks(2);
    check_value("bootstrap_o", 32'(boot), 32'(bootstrap));
    dps7 = ~boot;
    wait_clks(4);
    check_value("bootstrap_o", 32'(boot), 32'(bootstrap));
    check_value("dps2_o", 32'(1'b0), 32'(dps2));
    dps7 = boot;
    wait_clks(2);
  endtask

  // Sends one chip-select period MSB first and samples miso just before each rise
  task automatic spi_frame(input logic [SPI_FRAME_BITS-1:0] frame, input int nbits,
                           output logic [DATA_W-1:0] rdata);
    logic [SPI_FRAME_BITS-1:0] bits;
    bits  = frame;
    rdata = '0;
    dps3  = 1'b0;
    wait_clks(HALF_CLKS);
    for (int i = 0; i < nbits; i++) begin
      dps1 = bits[SPI_FRAME_BITS-1];
      bits = bits << 1;
      wait_clks(HALF_CLKS);
      if (frame[SPI_FRAME_BITS-1]) begin
        check_value("dps2_o during write", 32'(1'b0), 32'(dps2));
      end else if (i > FRAME_ADDR_W) begin
        rdata = {rdata[DATA_W-2:0], dps2};
      end
      dps0 = 1'b1;
      wait_clks(HALF_CLKS);
      dps0 = 1'b0;
    end
    wait_clks(HALF_CLKS);
    dps3 = 1'b1;
    dps1 = 1'b0;
    wait_clks(HALF_CLKS);
  endtask

  task automatic spi_write(input logic [FRAME_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input int nbits);
    int                status_before, log_before;
    logic [DATA_W-1:0] status_prev, log_prev, rd_dummy;
    logic [RAM_AW-1:0] word;
    logic              full;
    status_before = status_pulses;
    log_before    = log_pulses;
    status_prev   = status_data;
    log_prev      = log_data;
    word          = addr[RAM_AW-1:0];
    full          = (nbits == SPI_FRAME_BITS);
    spi_frame({1'b1, addr, data}, nbits, rd_dummy);
    check_value("test_status_valid_o pulses",
                32'(full && word == SW_TEST_STATUS_ADDR), 32'(status_pulses - status_before));
    check_value("log_valid_o pulses",
                32'(full && word == SW_LOG_ADDR), 32'(log_pulses - log_before));
    if (full) begin
      model[int'(word)] = data;
      if (word == SW_TEST_STATUS_ADDR) begin
        check_value("test_status_o", data, status_data);
      end
      if (word == SW_LOG_ADDR) begin
        check_value("log_data_o", data, log_data);
      end
    end else begin
      check_value("test_status_o", status_prev, status_data);
      check_value("log_data_o", log_prev, log_data);
    end
  endtask

  task automatic spi_read(input logic [FRAME_ADDR_W-1:0] addr);
    logic [DATA_W-1:0] rdata;
    spi_frame({1'b0, addr, {DATA_W{1'b0}}}, SPI_FRAME_BITS, rdata);
    check_value("dps2_o read data", model[int'(addr[RAM_AW-1:0])], rdata);
  endtask

  // One tck period; tdo is taken just before the rising edge
  task automatic jtag_clock(input logic tms, input logic tdi, output logic tdo);
    dps3 = tms;
    dps1 = tdi;
    wait_clks(HALF_CLKS);
    tdo  = dps2;
    dps0 = 1'b1;
    wait_clks(HALF_CLKS);
    dps0 = 1'b0;
  endtask

  // From Run-Test/Idle through Capture, Shift and Update back to Run-Test/Idle
  task automatic jtag_scan(input logic to_ir, input int nbits, input logic [DATA_W-1:0] din,
                           output logic [DATA_W-1:0] dout);
    logic [DATA_W-1:0] shreg;
    logic              tdo;
    shreg = din;
    dout  = '0;
    jtag_clock(1'b1, 1'b0, tdo);
    check_value("dps2_o outside shift", 32'(1'b0), 32'(tdo));
    if (to_ir) begin
      jtag_clock(1'b1, 1'b0, tdo);
    end
    jtag_clock(1'b0, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    for (int i = 0; i < nbits; i++) begin
      jtag_clock(i == nbits - 1, shreg[0], tdo);
      shreg = shreg >> 1;
      dout  = {tdo, dout[DATA_W-1:1]};
    end
    dout = dout >> (DATA_W - nbits);
    jtag_clock(1'b1, 1'b0, tdo);
    check_value("dps2_o outside shift", 32'(1'b0), 32'(tdo));
    jtag_clock(1'b0, 1'b0, tdo);
  endtask

  initial begin
    logic [31:0]             rnd;
    logic [FRAME_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]       dout;
    logic                    tdo;
    arst_n = 1'b0;
    dps0   = 1'b0;
    dps1   = 1'b0;
    dps3   = 1'b1;
    dps4   = 1'b1;
    dps6   = 1'b0;
    dps7   = 1'b0;

    apply_reset(1'b0, 1'b1);
    apply_reset(1'b1, 1'b0);
    apply_reset(1'b0, 1'b0);

    // Random writes and then reads back with every other address aliased
    for (int i = 0; i < NUM_WRITES; i++) begin
      rnd  = lcg_next();
      addr = rnd[30:16];
      rnd  = lcg_next();
      spi_write(addr, rnd, SPI_FRAME_BITS);
      addr_list.push_back(addr);
    end
    for (int i = 0; i < NUM_WRITES; i++) begin
      addr = addr_list[i];
      if (i % 2 == 1) begin
        addr = addr ^ 15'h5400;
      end
      spi_read(addr);
    end

    // Status and log words and a frame cut short at 30 bits
    spi_write({5'd0, SW_TEST_STATUS_ADDR}, 32'hC0DE_0001, SPI_FRAME_BITS);
    spi_write({5'h11, SW_LOG_ADDR}, 32'h0000_10A5, SPI_FRAME_BITS);
    spi_write({5'd0, SW_TEST_STATUS_ADDR}, 32'hDEAD_0BAD, 30);
    spi_read({5'd0, SW_TEST_STATUS_ADDR});

    // Reset the TAP by tms and read IDCODE
    apply_reset(1'b1, 1'b1);
    repeat (5) jtag_clock(1'b1, 1'b0, tdo);
    jtag_clock(1'b0, 1'b0, tdo);
    jtag_scan(1'b0, DATA_W, '0, dout);
    check_value("IDCODE", JTAG_IDCODE, dout);

    // Capture-IR pattern is 0101 and bypass delays tdi by one bit
    jtag_scan(1'b1, JTAG_IR_W, DATA_W'(JTAG_IR_BYPASS), dout);
    check_value("IR capture", 32'h0000_0005, dout);
    rnd = lcg_next();
    jtag_scan(1'b0, DATA_W, rnd, dout);
    check_value("BYPASS data", {rnd[DATA_W-2:0], 1'b0}, dout);

    // trst_n brings back IDCODE
    dps4 = 1'b0;
    wait_clks(2 * HALF_CLKS);
    dps4 = 1'b1;
    wait_clks(HALF_CLKS);
    jtag_clock(1'b0, 1'b0, tdo);
    jtag_scan(1'b0, DATA_W, '0, dout);
    check_value("IDCODE after trst_n", JTAG_IDCODE, dout);

    wait_clks(4);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the frame count
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/chip_io_pkg.sv
logic/strap_sampler.sv
logic/dps_pin_mux.sv
logic/jtag_tap.sv
logic/spi_frame_rx.sv
logic/main_ram.sv
logic/sw_status_monitor.sv
logic/chip_io_top.sv
dv/tb_chip_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the chip I/O testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_chip_io \
  -Mdir obj_dir -o tb_chip_io
./obj_dir/tb_chip_io | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
